// File: Bender.yml
package:
  name: exe_slice

sources:
  - common/exe_pkg.sv
  - exeu/alu.sv
  - exeu/npc_unit.sv
  - exeu/exeu.sv
  - logic/pipe_reg.sv
  - logic/exe_top.sv
  - target: test
    files:
      - tests/exe_chk.sv
      - tests/exe_tb.sv

// File: common/exe_pkg.sv
// shared encodings and stage payloads for the RV32 execute slice
// register addresses are 4 bits wide, so only x0..x15 are reachable (RV32E style)
`default_nettype none

package exe_pkg;

	// alu operation, codes 11..15 give zero
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_SLL   = 4'd2,
		ALU_SLT   = 4'd3,
		ALU_SLTU  = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SRA   = 4'd7,
		ALU_OR    = 4'd8,
		ALU_AND   = 4'd9,
		ALU_PASSB = 4'd10
	} alu_op_e;

	// jump kind, blt/bge also cover the unsigned forms via slt/sltu
	typedef enum logic [2:0] {
		JMP_NONE = 3'd0,
		JMP_JAL  = 3'd1,
		JMP_JALR = 3'd2,
		JMP_BEQ  = 3'd3,
		JMP_BNE  = 3'd4,
		JMP_BLT  = 3'd5,
		JMP_BGE  = 3'd6,
		JMP_RSVD = 3'd7
	} jump_e;

	// gpr write-back source
	typedef enum logic [1:0] {
		WB_NONE = 2'd0,
		WB_ALU  = 2'd1,
		WB_MEM  = 2'd2,
		WB_DATA = 2'd3
	} wb_sel_e;

	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_rw_e;

	// payload held by the ID/EX register
	typedef struct packed {
		logic        irq;
		logic        is_break;
		logic        gpr_we;
		logic        csr_we;
		logic [3:0]  gpr_waddr;
		logic [11:0] csr_waddr;
		wb_sel_e     wb_sel;
		mem_rw_e     mem_rw;
		logic [2:0]  mem_mask;
		alu_op_e     alu_op;
		jump_e       jump;
		logic [31:0] alu_a;
		logic [31:0] alu_b;
		// sequential / mret / ecall target
		logic [31:0] pc_seq;
		logic [31:0] pc_add_imm;
		logic [31:0] pc_add_4;
		logic [31:0] wdata_gpr;
		logic [31:0] wdata_csr;
	} id_ex_t;

	// payload held by the EX/MEM register
	typedef struct packed {
		logic        irq;
		logic        is_break;
		logic        gpr_we;
		logic        csr_we;
		logic [3:0]  gpr_waddr;
		logic [11:0] csr_waddr;
		wb_sel_e     wb_sel;
		mem_rw_e     mem_rw;
		logic [2:0]  mem_mask;
		logic [31:0] alu_result;
		// already resolved against wb_sel
		logic [31:0] wdata_gpr;
		logic [31:0] wdata_csr;
		// kept only for commit tracing
		logic [31:0] npc;
	} ex_mem_t;

endpackage

`default_nettype wire

// File: exeu/alu.sv
// combinational RV32 integer ALU; shift amount taken from b[4:0]
// zf/cf/of always reflect a - b, whatever op is selected
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  exe_pkg::alu_op_e op,
	input  logic [31:0]      a,
	input  logic [31:0]      b,
	output logic [31:0]      result,
	output logic             zf,
	output logic             cf,
	output logic             of
);

	import exe_pkg::*;

	// subtract path, extra bit catches the borrow
	logic [32:0] sub_full;
	logic [31:0] diff;
	logic [4:0]  shamt;
	logic        lt_signed;

	assign sub_full = {1'b0, a} - {1'b0, b};
	assign diff     = sub_full[31:0];
	assign shamt    = b[4:0];

	// flags for branch compares
	assign zf = (diff == 32'd0);
	// borrow out, set when a < b unsigned
	assign cf = sub_full[32];
	// operands of opposite sign and result sign flipped from a
	assign of = (a[31] ^ b[31]) & (a[31] ^ diff[31]);

	// signed less-than corrected for overflow
	assign lt_signed = diff[31] ^ of;

	always_comb begin
		case (op)
			ALU_ADD:   result = a + b;
			ALU_SUB:   result = diff;
			ALU_SLL:   result = a << shamt;
			ALU_SLT:   result = {31'd0, lt_signed};
			ALU_SLTU:  result = {31'd0, cf};
			ALU_XOR:   result = a ^ b;
			ALU_SRL:   result = a >> shamt;
			// arithmetic shift fills with the sign of a
			ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
			ALU_OR:    result = a | b;
			ALU_AND:   result = a & b;
			// lui, immediate already placed in b
			ALU_PASSB: result = b;
			default:   result = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

// File: exeu/exeu.sv
// execute stage, purely combinational; holds no state of its own
// redirect is only reported here, the fetch side does the flush
`timescale 1ns/1ps
`default_nettype none

module exeu (
	input  logic             in_valid,
	output logic             in_ready,
	input  exe_pkg::id_ex_t  in_payload,
	output logic             out_valid,
	input  logic             out_ready,
	output exe_pkg::ex_mem_t out_payload,
	output logic             redirect_valid,
	output logic [31:0]      redirect_pc,
	output logic             fw_is_load,
	output logic [31:0]      fw_data
);

	import exe_pkg::*;

	logic [31:0] alu_result;
	logic        zf;
	logic [31:0] npc;
	logic [31:0] wb_data;

	// handshake passes straight through
	assign out_valid = in_valid;
	assign in_ready  = out_ready;

	// cf/of only feed the alu's own compares
	alu u_alu (
		.op     (in_payload.alu_op),
		.a      (in_payload.alu_a),
		.b      (in_payload.alu_b),
		.result (alu_result),
		.zf     (zf),
		.cf     (),
		.of     ()
	);

	npc_unit u_npc (
		.jump       (in_payload.jump),
		.pc_seq     (in_payload.pc_seq),
		.pc_add_imm (in_payload.pc_add_imm),
		.alu_result (alu_result),
		.zf         (zf),
		.npc        (npc)
	);

	// jal target is resolved in decode, so it never redirects
	assign redirect_valid = in_valid && (in_payload.jump != JMP_JAL) &&
		(npc != in_payload.pc_add_4);
	assign redirect_pc = npc;

	// gpr data, alu result only for wb_sel alu
	assign wb_data = (in_payload.wb_sel == WB_ALU) ? alu_result : in_payload.wdata_gpr;

	// forwarding towards the hazard side
	assign fw_is_load = in_valid && (in_payload.mem_rw == MEM_LOAD);
	assign fw_data    = wb_data;

	// control fields pass unchanged
	always_comb begin
		out_payload.irq        = in_payload.irq;
		out_payload.is_break   = in_payload.is_break;
		out_payload.gpr_we     = in_payload.gpr_we;
		out_payload.csr_we     = in_payload.csr_we;
		out_payload.gpr_waddr  = in_payload.gpr_waddr;
		out_payload.csr_waddr  = in_payload.csr_waddr;
		out_payload.wb_sel     = in_payload.wb_sel;
		out_payload.mem_rw     = in_payload.mem_rw;
		out_payload.mem_mask   = in_payload.mem_mask;
		out_payload.alu_result = alu_result;
		out_payload.wdata_gpr  = wb_data;
		out_payload.wdata_csr  = in_payload.wdata_csr;
		out_payload.npc        = npc;
	end

endmodule

`default_nettype wire

// File: exeu/npc_unit.sv
// next-pc select; a not-taken branch falls back to pc_seq
// blt/bge expect the alu to have run slt or sltu
`timescale 1ns/1ps
`default_nettype none

module npc_unit (
	input  exe_pkg::jump_e jump,
	input  logic [31:0]    pc_seq,
	input  logic [31:0]    pc_add_imm,
	input  logic [31:0]    alu_result,
	input  logic           zf,
	output logic [31:0]    npc
);

	import exe_pkg::*;

	// compare outcome left in bit 0 by slt/sltu
	logic cmp_lt;

	assign cmp_lt = alu_result[0];

	always_comb begin
		case (jump)
			// sequential, mret or ecall target
			JMP_NONE: npc = pc_seq;
			JMP_JAL:  npc = pc_add_imm;
			// jalr target with bit 0 forced low
			JMP_JALR: npc = {alu_result[31:1], 1'b0};
			// equal when the subtract gives zero
			JMP_BEQ:  npc = zf ? pc_add_imm : pc_seq;
			JMP_BNE:  npc = zf ? pc_seq : pc_add_imm;
			JMP_BLT:  npc = cmp_lt ? pc_add_imm : pc_seq;
			JMP_BGE:  npc = cmp_lt ? pc_seq : pc_add_imm;
			// reserved code behaves as no jump
			default:  npc = pc_seq;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/exe_top.sv
// ID/EX register, execute stage and EX/MEM register; 2-cycle latency
// redirect and forwarding outputs track the item sitting in ID/EX
`timescale 1ns/1ps
`default_nettype none

module exe_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	output logic             in_ready,
	input  exe_pkg::id_ex_t  in_op,
	output logic             out_valid,
	input  logic             out_ready,
	output exe_pkg::ex_mem_t out_op,
	output logic             redirect_valid,
	output logic [31:0]      redirect_pc,
	output logic             fw_is_load,
	output logic [31:0]      fw_data
);

	import exe_pkg::*;

	// ID/EX register towards the execute stage
	logic    idex_valid;
	logic    idex_ready;
	id_ex_t  idex_data;

	// execute stage towards the EX/MEM register
	logic    ex_valid;
	logic    ex_ready;
	ex_mem_t ex_data;

	pipe_reg #(
		.payload_t (id_ex_t)
	) id_ex (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_op),
		.out_valid (idex_valid),
		.out_ready (idex_ready),
		.out_data  (idex_data)
	);

	// combinational, ready and valid pass through
	exeu exeu (
		.in_valid       (idex_valid),
		.in_ready       (idex_ready),
		.in_payload     (idex_data),
		.out_valid      (ex_valid),
		.out_ready      (ex_ready),
		.out_payload    (ex_data),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.fw_is_load     (fw_is_load),
		.fw_data        (fw_data)
	);

	// holds its item while out_ready is low
	pipe_reg #(
		.payload_t (ex_mem_t)
	) ex_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (ex_valid),
		.in_ready  (ex_ready),
		.in_data   (ex_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_op)
	);

endmodule

`default_nettype wire

// File: logic/pipe_reg.sv
// single-entry valid/ready stage register, full throughput
// in_ready depends combinationally on out_ready
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	// accept when empty or when the held item leaves this cycle
	assign in_ready = !valid_q || out_ready;

	// valid follows in_valid whenever the slot is free
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	// payload only loads on a transfer in
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

endmodule

`default_nettype wire

// File: src.f
common/exe_pkg.sv
exeu/alu.sv
exeu/npc_unit.sv
exeu/exeu.sv
logic/pipe_reg.sv
logic/exe_top.sv
tests/exe_chk.sv
tests/exe_tb.sv

// File: tests/exe_chk.sv
// handshake and reset properties on the exe_top output side
// sampled on the rising edge, stall rules disabled while in reset
`timescale 1ns/1ps
`default_nettype none

module exe_chk (
	input logic             clk,
	input logic             rst_n,
	input logic             out_valid,
	input logic             out_ready,
	input exe_pkg::ex_mem_t out_op,
	input logic             redirect_valid,
	input logic             fw_is_load
);

	int n_fail = 0;

	// a stalled item keeps its valid
	valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid)
		else begin
			n_fail++;
			$error("out_valid dropped while out_ready was low");
		end

	// and keeps its payload
	data_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_op))
		else begin
			n_fail++;
			$error("out_op changed while stalled");
		end

	// reset edge clears both stages
	reset_idle: assert property (@(posedge clk)
		!rst_n |=> !out_valid && !redirect_valid && !fw_is_load)
		else begin
			n_fail++;
			$error("valid output seen in the cycle after reset");
		end

endmodule

bind exe_top exe_chk chk (
	.clk            (clk),
	.rst_n          (rst_n),
	.out_valid      (out_valid),
	.out_ready      (out_ready),
	.out_op         (out_op),
	.redirect_valid (redirect_valid),
	.fw_is_load     (fw_is_load)
);

`default_nettype wire

// File: tests/exe_tb.sv
// random-stimulus testbench for exe_top, expected values from a queue-based model
// redirect and forwarding checked against a shadow copy of the ID/EX slot
`timescale 1ns/1ps
`default_nettype none

module exe_tb;

	import exe_pkg::*;

	localparam int N_STREAM = 200;
	localparam int N_FLOW   = 300;
	localparam int N_STALL  = 100;
	localparam int N_TOTAL  = N_STREAM + N_FLOW + N_STALL;

	logic    clk;
	logic    rst_n;
	logic    in_valid;
	logic    in_ready;
	id_ex_t  in_op;
	logic    out_valid;
	logic    out_ready;
	ex_mem_t out_op;
	logic    redirect_valid;
	logic [31:0] redirect_pc;
	logic    fw_is_load;
	logic [31:0] fw_data;

	// expected outputs in accept order, with the accept cycle
	ex_mem_t exp_q[$];
	int      acc_q[$];
	int      cycle;
	int      errors;
	int      n_pass;
	int      n_fail;
	bit      lat_check;
	bit      took;
	// shadow pipeline state
	bit      sh_idex_v;
	bit      sh_mem_v;
	id_ex_t  sh_idex;
	// expected execute outputs for the item in ID/EX
	ex_mem_t sh_exp;
	bit      ex_rdy;
	bit      id_rdy;

	exe_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#((N_TOTAL + 50) * 40 * 4);
		$display("watchdog expired before all tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic report_mismatch(string what);
		errors++;
		$display("[FAIL] t=%0d ns: %s mismatch", $time, what);
	endtask

	function automatic int total_errors();
		return errors + uut.chk.n_fail;
	endfunction

	// integer ops straight from the RV32 definitions
	function automatic logic [31:0] ref_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
		case (op)
			ALU_ADD:   return a + b;
			ALU_SUB:   return a - b;
			ALU_SLL:   return a << b[4:0];
			ALU_SLT:   return {31'd0, $signed(a) < $signed(b)};
			ALU_SLTU:  return {31'd0, a < b};
			ALU_XOR:   return a ^ b;
			ALU_SRL:   return a >> b[4:0];
			ALU_SRA:   return $signed(a) >>> b[4:0];
			ALU_OR:    return a | b;
			ALU_AND:   return a & b;
			ALU_PASSB: return b;
			default:   return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] ref_npc(id_ex_t i);
		logic [31:0] res;
		res = ref_alu(i.alu_op, i.alu_a, i.alu_b);
		case (i.jump)
			JMP_JAL:  return i.pc_add_imm;
			JMP_JALR: return {res[31:1], 1'b0};
			JMP_BEQ:  return (i.alu_a == i.alu_b) ? i.pc_add_imm : i.pc_seq;
			JMP_BNE:  return (i.alu_a != i.alu_b) ? i.pc_add_imm : i.pc_seq;
			JMP_BLT:  return res[0] ? i.pc_add_imm : i.pc_seq;
			JMP_BGE:  return res[0] ? i.pc_seq : i.pc_add_imm;
			default:  return i.pc_seq;
		endcase
	endfunction

	function automatic ex_mem_t expect_out(id_ex_t i);
		ex_mem_t o;
		{o.irq, o.is_break, o.gpr_we, o.csr_we} = {i.irq, i.is_break, i.gpr_we, i.csr_we};
		{o.gpr_waddr, o.csr_waddr} = {i.gpr_waddr, i.csr_waddr};
		{o.wb_sel, o.mem_rw, o.mem_mask} = {i.wb_sel, i.mem_rw, i.mem_mask};
		o.alu_result = ref_alu(i.alu_op, i.alu_a, i.alu_b);
		o.wdata_gpr  = (i.wb_sel == WB_ALU) ? o.alu_result : i.wdata_gpr;
		o.wdata_csr  = i.wdata_csr;
		o.npc        = ref_npc(i);
		return o;
	endfunction

	// equal operands and pc+4 targets show up often enough to hit the corners
	function automatic id_ex_t random_op();
		id_ex_t op;
		logic [31:0] r;
		r = $urandom;
		{op.irq, op.is_break, op.gpr_we, op.csr_we} = r[3:0];
		op.gpr_waddr  = r[7:4];
		op.csr_waddr  = r[19:8];
		op.wb_sel     = wb_sel_e'(r[21:20]);
		op.mem_rw     = mem_rw_e'($urandom_range(2));
		op.mem_mask   = r[24:22];
		op.alu_op     = alu_op_e'(r[28:25]);
		op.jump       = jump_e'(r[31:29]);
		op.alu_a      = $urandom;
		op.alu_b      = ($urandom_range(3) == 0) ? op.alu_a : $urandom;
		op.pc_add_4   = {$urandom_range(32'h3fff_ffff), 2'b00} + 32'd4;
		op.pc_seq     = ($urandom_range(3) != 0) ? op.pc_add_4 : $urandom;
		op.pc_add_imm = ($urandom_range(3) == 0) ? op.pc_add_4 : $urandom;
		op.wdata_gpr  = $urandom;
		op.wdata_csr  = $urandom;
		return op;
	endfunction

	task automatic compare_item(ex_mem_t got, ex_mem_t exp);
		assert (got.alu_result == exp.alu_result) else report_mismatch("alu_result");
		assert (got.wdata_gpr == exp.wdata_gpr) else report_mismatch("wdata_gpr");
		assert (got.npc == exp.npc) else report_mismatch("npc");
		assert (got == exp) else report_mismatch("out_op");
	endtask

	// sample mid-cycle, then advance the shadow to the next edge
	always @(negedge clk) begin
		if (!rst_n) begin
			sh_idex_v = 1'b0;
			sh_mem_v  = 1'b0;
		end else begin
			cycle++;
			sh_exp = expect_out(sh_idex);
			ex_rdy = !sh_mem_v || out_ready;
			id_rdy = !sh_idex_v || ex_rdy;
			assert (in_ready == id_rdy) else report_mismatch("in_ready");
			assert (out_valid == sh_mem_v) else report_mismatch("out_valid");
			assert (redirect_valid == (sh_idex_v && sh_idex.jump != JMP_JAL &&
				sh_exp.npc != sh_idex.pc_add_4)) else report_mismatch("redirect_valid");
			assert (fw_is_load == (sh_idex_v && sh_idex.mem_rw == MEM_LOAD))
				else report_mismatch("fw_is_load");
			if (sh_idex_v) begin
				assert (redirect_pc == sh_exp.npc) else report_mismatch("redirect_pc");
				assert (fw_data == sh_exp.wdata_gpr) else report_mismatch("fw_data");
			end
			if (out_valid && out_ready && exp_q.size() != 0) begin
				compare_item(out_op, exp_q.pop_front());
				if (lat_check) begin
					assert (cycle - acc_q[0] == 2) else report_mismatch("latency");
				end
				void'(acc_q.pop_front());
			end
			if (ex_rdy) sh_mem_v = sh_idex_v;
			if (id_rdy) begin
				sh_idex_v = in_valid;
				if (in_valid) begin
					sh_idex = in_op;
					exp_q.push_back(expect_out(in_op));
					acc_q.push_back(cycle);
				end
			end
		end
	end

	task automatic finish_test(string name, int err0, int items);
		if (total_errors() == err0) n_pass++;
		else n_fail++;
		$display("test %s: %0d items, %0d errors", name, items, total_errors() - err0);
	endtask

	// holds valid and payload until accepted
	task automatic run_flow(string name, int n, int in_pct, int out_pct, bit lat);
		int sent;
		int err0;
		err0      = total_errors();
		lat_check = lat;
		sent      = 0;
		took      = 1'b1;
		while (sent < n) begin
			@(posedge clk);
			#2;
			out_ready = ($urandom_range(99) < out_pct);
			if (took || !in_valid) begin
				in_valid = ($urandom_range(99) < in_pct);
				in_op    = random_op();
			end
			@(negedge clk);
			took = in_valid && in_ready;
			if (took) sent++;
		end
		@(posedge clk);
		#2;
		in_valid  = 1'b0;
		out_ready = 1'b1;
		while (exp_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
		finish_test(name, err0, n);
	endtask

	initial begin
		int err0;
		void'($urandom(32'h3500_a8e2));
		{errors, n_pass, n_fail, cycle} = '0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		in_op     = '0;
		lat_check = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// nothing accepted yet, so all valids must stay low
		err0 = total_errors();
		repeat (4) begin
			@(posedge clk);
			#2;
			out_ready = $urandom_range(1);
		end
		finish_test("reset_idle", err0, 0);
		run_flow("stream", N_STREAM, 100, 100, 1'b1);
		run_flow("random_flow", N_FLOW, 70, 60, 1'b0);
		run_flow("stall_heavy", N_STALL, 90, 20, 1'b0);
		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, total_errors());
		if (total_errors() == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
